// File: Makefile
# Verilator flow for the matrix modular multiplier
TOP   = tb_ntm_matrix_modular_multiplier
FLIST = ntm_matrix_modular_multiplier.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f $(FLIST) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "Run FAILED"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log || (echo "Run incomplete"; exit 1)
	@echo "Run passed"

clean:
	rm -rf obj_dir sim.log

// File: ntm_matrix_modular_multiplier.f
ntm_pkg.sv
ntm_scalar_modular_multiplier.sv
ntm_vector_modular_multiplier.sv
ntm_matrix_modular_multiplier.sv
tb_clock_gen.sv
tb_ntm_matrix_modular_multiplier.sv

// File: ntm_matrix_modular_multiplier.sv
/*
 * Element-wise modular product of two matrices, top of the subsystem.
 * Pulse start with cfg while idle, then stream cfg.rows * cfg.cols operand pairs
 * in row-major order; results leave with row and matrix end flags, then ready pulses.
 */

`default_nettype none
`timescale 1ns/1ps

module ntm_matrix_modular_multiplier (
  input  wire logic                  CLK,
  input  wire logic                  RST,
  input  wire logic                  start,
  input  wire ntm_pkg::ntm_cfg_t     cfg,
  output logic                       ready,
  input  wire logic                  data_in_valid,
  input  wire ntm_pkg::ntm_operand_t data_in,
  output logic                       data_in_ready,
  output logic                       data_out_valid,
  output ntm_pkg::ntm_result_t       data_out
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    MAT_IDLE,
    MAT_RUN
  } mat_state_t;

  mat_state_t                       state;

  // Run configuration, held from start to ready
  ntm_pkg::ntm_cfg_t                cfg_q;

  // Row sequencing
  logic [ntm_pkg::INDEX_WIDTH-1:0]  row_idx;
  logic                             last_row;
  logic                             row_start;
  logic                             row_done;

  // Raw vector unit output
  ntm_pkg::ntm_result_t             vec_out;

  assign last_row = (row_idx == cfg_q.rows - ntm_pkg::INDEX_WIDTH'(1));

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= MAT_IDLE;
      cfg_q     <= '0;
      row_idx   <= '0;
      row_start <= 1'b0;
      ready     <= 1'b0;
    end else begin
      // Pulses
      row_start <= 1'b0;
      ready     <= 1'b0;
      case (state)
        MAT_IDLE: begin
          // Start is only honoured here
          if (start) begin
            cfg_q     <= cfg;
            row_idx   <= '0;
            row_start <= 1'b1;
            state     <= MAT_RUN;
          end
        end
        MAT_RUN: begin
          // row_done comes with the last result of a row
          if (row_done) begin
            if (last_row) begin
              ready <= 1'b1;
              state <= MAT_IDLE;
            end else begin
              row_idx   <= row_idx + 1'b1;
              row_start <= 1'b1;
            end
          end
        end
        default: begin
          state <= MAT_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result stream
  //////////////////////////////////////////////////////////////////////

  // Value and row flag straight from the vector unit
  assign data_out.value       = vec_out.value;
  assign data_out.row_last    = vec_out.row_last;
  // End of run is the row end of the final row
  assign data_out.matrix_last = vec_out.row_last && last_row;

  //////////////////////////////////////////////////////////////////////
  // Vector unit
  //////////////////////////////////////////////////////////////////////

  // One row at a time, row length is the column count
  ntm_vector_modular_multiplier u_vector (
    .CLK            (CLK),
    .RST            (RST),
    .row_start      (row_start),
    .row_len        (cfg_q.cols),
    .modulo         (cfg_q.modulo),
    .data_in_valid  (data_in_valid),
    .data_in        (data_in),
    .data_in_ready  (data_in_ready),
    .data_out_valid (data_out_valid),
    .data_out       (vec_out),
    .row_done       (row_done)
  );

endmodule

`default_nettype wire

// File: ntm_pkg.sv
/*
 * Shared widths and packed payload types of the modular multiplier.
 * RTL and testbench reach these by scoped names such as ntm_pkg::ntm_cfg_t.
 */

`default_nettype none

package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Modulus, operands and results
  localparam int DATA_WIDTH  = 16;
  // Row and column counts and indexes
  localparam int INDEX_WIDTH = 8;
  // Scalar step counter, holds 0 .. DATA_WIDTH
  localparam int STEP_WIDTH  = 5;

  //////////////////////////////////////////////////////////////////////
  // Payload types
  //////////////////////////////////////////////////////////////////////

  // Run configuration, sampled at an honoured start
  typedef struct packed {
    logic [DATA_WIDTH-1:0]  modulo;
    logic [INDEX_WIDTH-1:0] rows;
    logic [INDEX_WIDTH-1:0] cols;
  } ntm_cfg_t;

  // One operand pair, both below the modulus
  typedef struct packed {
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
  } ntm_operand_t;

  // One output element with its position flags
  typedef struct packed {
    logic [DATA_WIDTH-1:0] value;
    logic                  row_last;
    logic                  matrix_last;
  } ntm_result_t;

endpackage

`default_nettype wire

// File: ntm_scalar_modular_multiplier.sv
/*
 * Iterative modular product of one operand pair, a * b mod modulo.
 * Pulse start for one cycle; ready and result follow DATA_WIDTH + 1 cycles later.
 * Operands must be below modulo, and modulo must stay stable while busy.
 */

`default_nettype none
`timescale 1ns/1ps

module ntm_scalar_modular_multiplier (
  input  wire logic                            CLK,
  input  wire logic                            RST,
  input  wire logic                            start,
  input  wire ntm_pkg::ntm_operand_t           operand,
  input  wire logic [ntm_pkg::DATA_WIDTH-1:0]  modulo,
  output logic                                 ready,
  output logic [ntm_pkg::DATA_WIDTH-1:0]       result
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Control
  logic                             busy;
  logic [ntm_pkg::STEP_WIDTH-1:0]   step_cnt;
  logic                             last_step;

  // Datapath registers
  logic [ntm_pkg::DATA_WIDTH-1:0]   a_q;
  logic [ntm_pkg::DATA_WIDTH-1:0]   b_q;
  logic [ntm_pkg::DATA_WIDTH-1:0]   acc;

  // One step of the double-and-add loop
  logic [ntm_pkg::DATA_WIDTH:0]     dbl;
  logic [ntm_pkg::DATA_WIDTH:0]     dbl_sub;
  logic [ntm_pkg::DATA_WIDTH-1:0]   dbl_red;
  logic [ntm_pkg::DATA_WIDTH:0]     sum;
  logic [ntm_pkg::DATA_WIDTH:0]     sum_sub;
  logic [ntm_pkg::DATA_WIDTH-1:0]   sum_red;
  logic [ntm_pkg::DATA_WIDTH-1:0]   acc_next;

  //////////////////////////////////////////////////////////////////////
  // Step arithmetic
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Doubling, at most 2m - 2, one subtraction is enough
    dbl     = {acc, 1'b0};
    dbl_sub = dbl - {1'b0, modulo};
    dbl_red = (dbl >= {1'b0, modulo}) ? dbl_sub[ntm_pkg::DATA_WIDTH-1:0]
                                      : dbl[ntm_pkg::DATA_WIDTH-1:0];
    // Add a when the current bit of b is set
    sum     = {1'b0, dbl_red} + {1'b0, a_q};
    sum_sub = sum - {1'b0, modulo};
    sum_red = (sum >= {1'b0, modulo}) ? sum_sub[ntm_pkg::DATA_WIDTH-1:0]
                                      : sum[ntm_pkg::DATA_WIDTH-1:0];
    // MSB of b first
    acc_next = b_q[ntm_pkg::DATA_WIDTH-1] ? sum_red : dbl_red;
  end

  assign last_step = (step_cnt == ntm_pkg::STEP_WIDTH'(ntm_pkg::DATA_WIDTH - 1));

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      // Ready is a single-cycle pulse
      ready <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy     <= 1'b1;
          step_cnt <= '0;
        end
      end else begin
        step_cnt <= step_cnt + 1'b1;
        if (last_step) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!busy && start) begin
      a_q <= operand.a;
      b_q <= operand.b;
      acc <= '0;
    end else if (busy) begin
      acc <= acc_next;
      // Next bit of b moves into the MSB
      b_q <= {b_q[ntm_pkg::DATA_WIDTH-2:0], 1'b0};
      if (last_step) begin
        result <= acc_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: ntm_vector_modular_multiplier.sv
/*
 * Row sequencer around the scalar modular multiplier.
 * After row_start it takes row_len operand pairs over a valid/ready stream,
 * one in flight at a time, and returns each product with row_last on the final one.
 */

`default_nettype none
`timescale 1ns/1ps

module ntm_vector_modular_multiplier (
  input  wire logic                            CLK,
  input  wire logic                            RST,
  input  wire logic                            row_start,
  input  wire logic [ntm_pkg::INDEX_WIDTH-1:0] row_len,
  input  wire logic [ntm_pkg::DATA_WIDTH-1:0]  modulo,
  input  wire logic                            data_in_valid,
  input  wire ntm_pkg::ntm_operand_t           data_in,
  output logic                                 data_in_ready,
  output logic                                 data_out_valid,
  output ntm_pkg::ntm_result_t                 data_out,
  output logic                                 row_done
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    VEC_IDLE,
    VEC_WAIT,
    VEC_MUL
  } vec_state_t;

  vec_state_t                       state;
  logic [ntm_pkg::INDEX_WIDTH-1:0]  elem_idx;
  logic                             elem_last;
  logic                             in_xfer;

  // Scalar unit side
  logic                             mul_start;
  ntm_pkg::ntm_operand_t            mul_operand;
  logic                             mul_ready;
  logic [ntm_pkg::DATA_WIDTH-1:0]   mul_result;

  // Handshake, ready is only raised in VEC_WAIT
  assign in_xfer   = data_in_ready && data_in_valid;
  assign elem_last = (elem_idx == row_len - ntm_pkg::INDEX_WIDTH'(1));

  //////////////////////////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= VEC_IDLE;
      elem_idx       <= '0;
      data_in_ready  <= 1'b0;
      mul_start      <= 1'b0;
      data_out_valid <= 1'b0;
      row_done       <= 1'b0;
    end else begin
      // Pulses
      mul_start      <= 1'b0;
      data_out_valid <= 1'b0;
      row_done       <= 1'b0;
      case (state)
        VEC_IDLE: begin
          // First element of a row is offered right away
          if (row_start) begin
            elem_idx      <= '0;
            data_in_ready <= 1'b1;
            state         <= VEC_WAIT;
          end
        end
        VEC_WAIT: begin
          if (in_xfer) begin
            data_in_ready <= 1'b0;
            mul_start     <= 1'b1;
            state         <= VEC_MUL;
          end else begin
            data_in_ready <= 1'b1;
          end
        end
        VEC_MUL: begin
          if (mul_ready) begin
            data_out_valid <= 1'b1;
            if (elem_last) begin
              row_done <= 1'b1;
              state    <= VEC_IDLE;
            end else begin
              // Ready comes back one cycle after the result
              elem_idx <= elem_idx + 1'b1;
              state    <= VEC_WAIT;
            end
          end
        end
        default: begin
          state <= VEC_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand and result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (in_xfer) begin
      mul_operand <= data_in;
    end
    if (state == VEC_MUL && mul_ready) begin
      data_out.value       <= mul_result;
      data_out.row_last    <= elem_last;
      // Filled in by the matrix unit
      data_out.matrix_last <= 1'b0;
    end
  end

  ntm_scalar_modular_multiplier u_scalar (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .operand (mul_operand),
    .modulo  (modulo),
    .ready   (mul_ready),
    .result  (mul_result)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * CLK has an 8 ns period; RST is held high for the first 16 rising edges.
 */

`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  // 8 ns period
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Released just after an edge, like the other stimulus
  initial begin
    RST = 1'b1;
    repeat (16) @(posedge CLK);
    #1 RST = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_ntm_matrix_modular_multiplier.sv
/*
 * Testbench of the matrix modular multiplier.
 * Random and directed runs are checked against a model of a * b mod m with
 * row-major end flags. Inputs change 1 ns after a rising edge, outputs are
 * sampled on the falling edge, and a watchdog bounds the run.
 */

`default_nettype none
`timescale 1ns/1ps

module tb_ntm_matrix_modular_multiplier;

  //////////////////////////////////////////////////////////////////////
  // Run limits
  //////////////////////////////////////////////////////////////////////

  localparam int MAX_GAP   = 5;
  // Upper bound on operand pairs over all tests
  localparam int MAX_ELEMS = 12 + 1 + 20 * 36 + 9 + 8 * 36 + 3 * 36;
  localparam int WATCHDOG_CYCLES =
    MAX_ELEMS * (ntm_pkg::DATA_WIDTH + 3 + MAX_GAP) + 5000;

  logic                  CLK;
  logic                  RST;
  logic                  start;
  ntm_pkg::ntm_cfg_t     cfg;
  logic                  ready;
  logic                  data_in_valid;
  ntm_pkg::ntm_operand_t data_in;
  logic                  data_in_ready;
  logic                  data_out_valid;
  ntm_pkg::ntm_result_t  data_out;

  integer                seed;
  int                    errors;
  int                    tests_passed;
  int                    tests_failed;
  int                    ready_count;
  int                    result_count;
  logic                  prev_matrix_last;
  // Expected results and pending operands, row-major
  ntm_pkg::ntm_result_t  exp_q[$];
  ntm_pkg::ntm_operand_t op_q[$];

  tb_clock_gen clk_gen (.CLK(CLK), .RST(RST));

  ntm_matrix_modular_multiplier dut0 (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .cfg            (cfg),
    .ready          (ready),
    .data_in_valid  (data_in_valid),
    .data_in        (data_in),
    .data_in_ready  (data_in_ready),
    .data_out_valid (data_out_valid),
    .data_out       (data_out)
  );

  //////////////////////////////////////////////////////////////////////
  // Model and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Plain a * b mod m in 32 bits
  function automatic logic [ntm_pkg::DATA_WIDTH-1:0] model_product(
    input logic [15:0] a, input logic [15:0] b, input logic [15:0] m);
    logic [31:0] full;
    full = {16'd0, a} * {16'd0, b};
    return ntm_pkg::DATA_WIDTH'(full % {16'd0, m});
  endfunction

  function automatic ntm_pkg::ntm_cfg_t make_cfg(input logic [15:0] m,
                                                 input logic [7:0] rows,
                                                 input logic [7:0] cols);
    ntm_pkg::ntm_cfg_t c;
    c.modulo = m;
    c.rows   = rows;
    c.cols   = cols;
    return c;
  endfunction

  // Modulus 2 .. 65535, sizes 1 .. max_dim
  function automatic ntm_pkg::ntm_cfg_t random_cfg(input int max_dim);
    ntm_pkg::ntm_cfg_t c;
    c.modulo = ntm_pkg::DATA_WIDTH'(32'd2 + $unsigned($random(seed)) % 32'd65534);
    c.rows   = ntm_pkg::INDEX_WIDTH'(32'd1 + $unsigned($random(seed)) % max_dim);
    c.cols   = ntm_pkg::INDEX_WIDTH'(32'd1 + $unsigned($random(seed)) % max_dim);
    return c;
  endfunction

  task automatic push_pair(input logic [15:0] a, input logic [15:0] b);
    ntm_pkg::ntm_operand_t op;
    op.a = a;
    op.b = b;
    op_q.push_back(op);
  endtask

  // Operands kept below the modulus
  task automatic fill_random_operands(input ntm_pkg::ntm_cfg_t c);
    for (int i = 0; i < int'(c.rows) * int'(c.cols); i++) begin
      push_pair(ntm_pkg::DATA_WIDTH'($unsigned($random(seed)) % {16'd0, c.modulo}),
                ntm_pkg::DATA_WIDTH'($unsigned($random(seed)) % {16'd0, c.modulo}));
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  // Offers every queued pair, holding valid and data until the transfer edge
  task automatic drive_operands(input int max_gap);
    ntm_pkg::ntm_operand_t op;
    int gap;
    while (op_q.size() > 0) begin
      op  = op_q.pop_front();
      gap = int'($unsigned($random(seed)) % (max_gap + 1));
      repeat (gap) next_cycle();
      data_in_valid = 1'b1;
      data_in       = op;
      while (!data_in_ready) next_cycle();
      next_cycle();
      data_in_valid = 1'b0;
    end
  endtask

  // One run from the queued operands; inject raises a start while busy
  task automatic run_matrix(input ntm_pkg::ntm_cfg_t run_cfg, input int max_gap,
                            input bit inject);
    ntm_pkg::ntm_result_t r;
    int idx;
    int elems;
    int rdy0;
    int res0;
    rdy0  = ready_count;
    res0  = result_count;
    elems = int'(run_cfg.rows) * int'(run_cfg.cols);
    idx   = 0;
    for (int row = 0; row < int'(run_cfg.rows); row++) begin
      for (int col = 0; col < int'(run_cfg.cols); col++) begin
        r.value       = model_product(op_q[idx].a, op_q[idx].b, run_cfg.modulo);
        r.row_last    = (col == int'(run_cfg.cols) - 1);
        // Final element in row-major order
        r.matrix_last = (idx == elems - 1);
        exp_q.push_back(r);
        idx++;
      end
    end
    cfg   = run_cfg;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    // The DUT must hold its own copy
    cfg   = random_cfg(6);
    fork
      drive_operands(max_gap);
      if (inject) begin
        repeat (4) next_cycle();
        cfg   = make_cfg(16'd7, 8'd1, 8'd1);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
      end
    join
    while (ready_count == rdy0) next_cycle();
    // Quiet afterwards, so no second run was started
    repeat (ntm_pkg::DATA_WIDTH + 8) begin
      next_cycle();
      check_value("data_in_ready", 32'd0, 32'(data_in_ready));
    end
    check_value("ready pulse count", 32'(rdy0 + 1), 32'(ready_count));
    check_value("result count", 32'(res0 + elems), 32'(result_count));
    check_value("expected queue size", 32'd0, 32'(exp_q.size()));
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor, falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin : monitor
    ntm_pkg::ntm_result_t exp_r;
    if (!RST) begin
      if (ready) begin
        ready_count++;
        check_value("ready after matrix_last", 32'd1, 32'(prev_matrix_last));
      end
      if (data_out_valid) begin
        result_count++;
        if (exp_q.size() == 0) begin
          $display("Error at %0t ns: a result arrived with nothing expected", $time);
          errors++;
        end else begin
          exp_r = exp_q.pop_front();
          check_value("data_out.value", 32'(exp_r.value), 32'(data_out.value));
          check_value("data_out.row_last", 32'(exp_r.row_last), 32'(data_out.row_last));
          check_value("data_out.matrix_last", 32'(exp_r.matrix_last),
                      32'(data_out.matrix_last));
        end
      end
      prev_matrix_last = data_out_valid && data_out.matrix_last;
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Error: the run timed out after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    ntm_pkg::ntm_cfg_t c;
    int e0;
    seed             = 32'h69e7_8935;
    start            = 1'b0;
    cfg              = '0;
    data_in_valid    = 1'b0;
    data_in          = '0;
    errors           = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    ready_count      = 0;
    result_count     = 0;
    prev_matrix_last = 1'b0;

    // Idle outputs after reset, then end flags of a 3x4 run
    e0 = errors;
    @(negedge RST);
    repeat (12) begin
      check_value("ready", 32'd0, 32'(ready));
      check_value("data_in_ready", 32'd0, 32'(data_in_ready));
      check_value("data_out_valid", 32'd0, 32'(data_out_valid));
      next_cycle();
    end
    c = make_cfg(16'd1000, 8'd3, 8'd4);
    fill_random_operands(c);
    run_matrix(c, 2, 1'b0);
    finish_test("reset idle and end flags", e0);

    e0 = errors;
    c = random_cfg(1);
    fill_random_operands(c);
    run_matrix(c, 0, 1'b0);
    finish_test("single element", e0);

    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      c = random_cfg(6);
      fill_random_operands(c);
      run_matrix(c, 0, 1'b0);
    end
    finish_test("twenty random matrices", e0);

    // Zero, m - 1, modulus 2 and the largest 16-bit modulus
    e0 = errors;
    push_pair(16'd0, 16'd0);
    push_pair(16'd65534, 16'd65534);
    push_pair(16'd0, 16'd65534);
    push_pair(16'd65534, 16'd1);
    run_matrix(make_cfg(16'd65535, 8'd2, 8'd2), 1, 1'b0);
    push_pair(16'd1, 16'd1);
    push_pair(16'd0, 16'd1);
    push_pair(16'd1, 16'd0);
    run_matrix(make_cfg(16'd2, 8'd1, 8'd3), 1, 1'b0);
    push_pair(16'd65520, 16'd65520);
    push_pair(16'd65520, 16'd2);
    run_matrix(make_cfg(16'd65521, 8'd2, 8'd1), 0, 1'b0);
    finish_test("edge operands", e0);

    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      c = random_cfg(6);
      fill_random_operands(c);
      run_matrix(c, MAX_GAP, 1'b0);
    end
    finish_test("random valid gaps", e0);

    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      c = random_cfg(6);
      fill_random_operands(c);
      run_matrix(c, 2, 1'b1);
    end
    finish_test("start while busy", e0);

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
